//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_dispatcher
FLIST     = flist.f
SRCS      = $(shell cat $(FLIST))
BIN       = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- beat_assembler.sv
/*
 * Beat assembler, the decode stage.
 *   collects eight 64-bit words into one beat, low word first
 *   derives the stream sideband from the first word
 *   holds the finished beat until the buffer takes it
 */

`timescale 1ns/1ns

module beat_assembler import dispatch_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  word_t  ififo_wdata,
	input  logic   ififo_wen,
	output logic   ififo_rdy,
	beat_if.source beat_o
);

	asm_state_t state;
	logic [2:0] idx;
	logic       accept;
	logic       last_word;

	beat_t  beat_q;
	keep_t  keep_q;
	tid_t   tid_q;
	tdest_t tdest_q;
	tuser_t tuser_q;
	logic   last_q;

	assign ififo_rdy = (state == COLLECT);
	assign accept    = ififo_wen && ififo_rdy;
	assign last_word = (idx == 3'(WORDS_PER_BEAT - 1));

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= COLLECT;
			idx   <= '0; // a partial beat is dropped.
		end else begin
			case (state)
				COLLECT: begin
					if (accept) begin
						idx <= idx + 3'd1; // wraps to zero after the last word.
						if (last_word)
							state <= HOLD;
					end
				end
				HOLD: begin
					if (beat_o.ready)
						state <= COLLECT;
				end
				default: state <= COLLECT;
			endcase
		end
	end

	// ------------------------------
	// beat and sideband registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (accept) begin
			beat_q[idx*WORD_W +: WORD_W] <= ififo_wdata; // word k lands in slot k.
			if (idx == 3'd0) begin
				keep_q  <= ififo_wdata;
				tid_q   <= ififo_wdata[7:0] ^ ififo_wdata[15:8];
				tdest_q <= ififo_wdata[7:0] ^ ififo_wdata[23:16];
				tuser_q <= ififo_wdata[31:0] ^ ififo_wdata[63:32];
				last_q  <= ififo_wdata[63] ^ ififo_wdata[0];
			end
		end
	end

	assign beat_o.valid = (state == HOLD);
	assign beat_o.data  = beat_q;
	assign beat_o.keep  = keep_q;
	assign beat_o.tid   = tid_q;
	assign beat_o.tdest = tdest_q;
	assign beat_o.tuser = tuser_q;
	assign beat_o.last  = last_q;

endmodule

//--- beat_buffer.sv
/*
 * Beat buffer, the execute stage.
 *   FIFO of beats on two block RAMs for data and sideband
 *   wrap-bit pointers for full and empty
 *   read tracking flag and output prefetch register
 */

`timescale 1ns/1ns

module beat_buffer import dispatch_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	beat_if.sink   beat_i,
	beat_if.source beat_o
);

	buf_ptr_t head; // oldest entry still held in RAM.
	buf_ptr_t tail;
	buf_ptr_t rd_next;
	logic     full;
	logic     wen;
	logic     rd_valid; // RAM output holds the entry at head.
	logic     rd_hold;
	logic     issue;
	logic     pf_load;
	logic     pf_valid;

	logic [BUF_AW-1:0] raddr;
	beat_t             rd_data;
	beat_t             pf_data;
	logic [SIDE_W-1:0] wr_side;
	logic [SIDE_W-1:0] rd_side;
	logic [SIDE_W-1:0] pf_side;

	// ------------------------------
	// write side
	// ------------------------------
	assign full = (tail[BUF_AW] != head[BUF_AW]) &&
		(tail[BUF_AW-1:0] == head[BUF_AW-1:0]);
	assign beat_i.ready = !full;
	assign wen          = beat_i.valid && !full;
	assign wr_side = {beat_i.keep, beat_i.tid, beat_i.tdest, beat_i.tuser, beat_i.last};

	// ------------------------------
	// read side
	// ------------------------------
	assign pf_load = rd_valid && (!pf_valid || beat_o.ready);
	assign rd_hold = rd_valid && !pf_load; // stalled read data is fetched again.
	assign rd_next = rd_valid ? head + buf_ptr_t'(1) : head;
	assign issue   = !rd_hold && (rd_next != tail);
	assign raddr   = rd_hold ? head[BUF_AW-1:0] : rd_next[BUF_AW-1:0];

	beat_ram #(
		.W  (BEAT_W),
		.AW (BUF_AW)
	) i_data_ram (
		.clk   (clk),
		.wen   (wen),
		.waddr (tail[BUF_AW-1:0]),
		.raddr (raddr),
		.wdata (beat_i.data),
		.rdata (rd_data)
	);

	beat_ram #(
		.W  (SIDE_W),
		.AW (BUF_AW)
	) i_side_ram (
		.clk   (clk),
		.wen   (wen),
		.waddr (tail[BUF_AW-1:0]),
		.raddr (raddr),
		.wdata (wr_side),
		.rdata (rd_side)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			head     <= '0;
			tail     <= '0;
			rd_valid <= 1'b0;
			pf_valid <= 1'b0;
		end else begin
			if (wen)
				tail <= tail + buf_ptr_t'(1);
			if (pf_load)
				head <= head + buf_ptr_t'(1); // the entry is freed once it is in the prefetch.
			rd_valid <= rd_hold || issue;
			if (pf_load)
				pf_valid <= 1'b1;
			else if (beat_o.ready)
				pf_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pf_load) begin
			pf_data <= rd_data;
			pf_side <= rd_side;
		end
	end

	assign beat_o.valid = pf_valid;
	assign beat_o.data  = pf_data;
	assign {beat_o.keep, beat_o.tid, beat_o.tdest, beat_o.tuser, beat_o.last} = pf_side;

endmodule

//--- beat_if.sv
/*
 * Beat link between pipeline stages.
 *   one 512-bit beat with its stream sideband
 *   valid/ready handshake with AXI4-Stream transfer rules
 *   source and sink modports
 */

`timescale 1ns/1ns

interface beat_if import dispatch_pkg::*; ();

	logic   valid;
	logic   ready;
	beat_t  data;
	keep_t  keep;
	tid_t   tid;
	tdest_t tdest;
	tuser_t tuser;
	logic   last;

	modport source (
		output valid,
		output data,
		output keep,
		output tid,
		output tdest,
		output tuser,
		output last,
		input  ready
	);

	modport sink (
		input  valid,
		input  data,
		input  keep,
		input  tid,
		input  tdest,
		input  tuser,
		input  last,
		output ready
	);

endinterface

//--- beat_ram.sv
/*
 * Simple dual-port block RAM.
 *   one write port and one read port on a single clock
 *   read data is registered, one cycle after the address
 */

`timescale 1ns/1ns

module beat_ram #(
	parameter int W  = 8,
	parameter int AW = 4
) (
	input  logic          clk,
	input  logic          wen,
	input  logic [AW-1:0] waddr,
	input  logic [AW-1:0] raddr,
	input  logic [W-1:0]  wdata,
	output logic [W-1:0]  rdata
);

	logic [W-1:0] mem [2**AW];

	always_ff @(posedge clk) begin
		if (wen)
			mem[waddr] <= wdata;
		rdata <= mem[raddr]; // read happens every cycle.
	end

endmodule

//--- dispatch_pkg.sv
/*
 * Shared definitions for the word-to-beat dispatcher.
 *   widths of words, beats and the stream sideband
 *   depth and address width of the beat FIFO
 *   typedefs for the typed fields and the assembler FSM states
 */

package dispatch_pkg;

	// ------------------------------
	// widths and depths
	// ------------------------------
	localparam int WORD_W         = 64;
	localparam int WORDS_PER_BEAT = 8;
	localparam int BEAT_W         = WORD_W * WORDS_PER_BEAT;
	localparam int BUF_DEPTH      = 16;
	localparam int BUF_AW         = 4;

	// ------------------------------
	// typed fields
	// ------------------------------
	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [BEAT_W-1:0]   beat_t;
	typedef logic [BEAT_W/8-1:0] keep_t;
	typedef logic [7:0]          tid_t;
	typedef logic [7:0]          tdest_t;
	typedef logic [31:0]         tuser_t;
	typedef logic [BUF_AW:0]     buf_ptr_t; // the top bit marks the wrap.

	// keep, tid, tdest, tuser and last as stored next to each beat.
	localparam int SIDE_W = $bits(keep_t) + $bits(tid_t) + $bits(tdest_t)
		+ $bits(tuser_t) + 1;

	typedef enum logic {
		COLLECT,
		HOLD
	} asm_state_t;

endpackage

//--- dispatcher.sv
/*
 * Dispatcher top level.
 *   word input with write enable and ready
 *   AXI4-Stream transmit port
 *   assembler, beat buffer and stream output joined by two beat links
 */

`timescale 1ns/1ns

module dispatcher import dispatch_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	output logic   tx_tvalid,
	output beat_t  tx_tdata,
	output keep_t  tx_tstrb,
	output keep_t  tx_tkeep,
	output tid_t   tx_tid,
	output tdest_t tx_tdest,
	output tuser_t tx_tuser,
	output logic   tx_tlast,
	input  logic   tx_tready,
	input  word_t  ififo_wdata,
	input  logic   ififo_wen,
	output logic   ififo_rdy
);

	beat_if asm_to_buf ();
	beat_if buf_to_out ();

	// ------------------------------
	// stages
	// ------------------------------
	beat_assembler i_assembler (
		.clk         (clk),
		.rst         (rst),
		.ififo_wdata (ififo_wdata),
		.ififo_wen   (ififo_wen),
		.ififo_rdy   (ififo_rdy),
		.beat_o      (asm_to_buf.source)
	);

	beat_buffer i_buffer (
		.clk    (clk),
		.rst    (rst),
		.beat_i (asm_to_buf.sink),
		.beat_o (buf_to_out.source)
	);

	tx_stream_out i_stream_out (
		.clk       (clk),
		.rst       (rst),
		.beat_i    (buf_to_out.sink),
		.tx_tvalid (tx_tvalid),
		.tx_tdata  (tx_tdata),
		.tx_tstrb  (tx_tstrb),
		.tx_tkeep  (tx_tkeep),
		.tx_tid    (tx_tid),
		.tx_tdest  (tx_tdest),
		.tx_tuser  (tx_tuser),
		.tx_tlast  (tx_tlast),
		.tx_tready (tx_tready)
	);

endmodule

//--- dispatcher_checker.sv
/*
 * Assertions bound to the dispatcher.
 *   stream output quiet after reset
 *   stalled beat held stable
 *   input ready always known
 */

`timescale 1ns/1ns

module dispatcher_checker import dispatch_pkg::*; (
	input logic  clk,
	input logic  rst,
	input logic  tx_tvalid,
	input logic  tx_tready,
	input beat_t tx_tdata,
	input logic  ififo_rdy
);

	a_quiet_after_reset: assert property (@(posedge clk) rst |=> !tx_tvalid)
		else $error("tx_tvalid high after reset");

	// a stalled beat keeps valid and data.
	a_stall_stable: assert property (@(posedge clk) disable iff (rst)
		(tx_tvalid && !tx_tready) |=> (tx_tvalid && $stable(tx_tdata)))
		else $error("stalled beat changed");

	a_rdy_known: assert property (@(posedge clk) !rst |-> !$isunknown(ififo_rdy))
		else $error("ififo_rdy unknown");

endmodule

bind dispatcher dispatcher_checker i_checker (
	.clk       (clk),
	.rst       (rst),
	.tx_tvalid (tx_tvalid),
	.tx_tready (tx_tready),
	.tx_tdata  (tx_tdata),
	.ififo_rdy (ififo_rdy)
);

//--- flist.f
dispatch_pkg.sv
beat_if.sv
beat_assembler.sv
beat_ram.sv
beat_buffer.sv
tx_stream_out.sv
dispatcher.sv
dispatcher_checker.sv
tb_dispatcher.sv

//--- tb_dispatcher.sv
/*
 * Directed testbench for the dispatcher.
 *   clock, reset, word driver and stream monitor
 *   reference model for beat data and sideband
 *   typed compare tasks, watchdog and five directed tests
 */

`timescale 1ns/1ns

module tb_dispatcher import dispatch_pkg::*; ();

	localparam int TOTAL_BEATS = 426;
	localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 200 + 1000;
	localparam int FIELDS_W = BEAT_W + 2 * $bits(keep_t) + $bits(tid_t) + $bits(tdest_t)
		+ $bits(tuser_t) + 1;

	logic   clk;
	logic   rst;
	logic   tx_tvalid;
	beat_t  tx_tdata;
	keep_t  tx_tstrb;
	keep_t  tx_tkeep;
	tid_t   tx_tid;
	tdest_t tx_tdest;
	tuser_t tx_tuser;
	logic   tx_tlast;
	logic   tx_tready;
	word_t  ififo_wdata;
	logic   ififo_wen;
	logic   ififo_rdy;

	int          errors = 0;
	string       cur_test = "none";
	logic [31:0] seed = 32'h32e9c013;
	logic        rand_ready = 1'b0;
	word_t       acc_words[$];

	beat_t  exp_data[$], got_data[$];
	keep_t  exp_keep[$], got_keep[$], got_strb[$];
	tid_t   exp_tid[$], got_tid[$];
	tdest_t exp_tdest[$], got_tdest[$];
	tuser_t exp_tuser[$], got_tuser[$];
	logic   exp_last[$], got_last[$];

	dispatcher i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// ------------------------------
	// reference model
	// ------------------------------
	task automatic model_beat();
		beat_t b;
		word_t w0;
		w0 = acc_words[0];
		for (int k = 0; k < WORDS_PER_BEAT; k++)
			b[k*WORD_W +: WORD_W] = acc_words[k];
		exp_data.push_back(b);
		exp_keep.push_back(w0);
		exp_tid.push_back(w0[7:0] ^ w0[15:8]);
		exp_tdest.push_back(w0[7:0] ^ w0[23:16]);
		exp_tuser.push_back(w0[31:0] ^ w0[63:32]);
		exp_last.push_back(w0[63] ^ w0[0]);
		acc_words.delete();
	endtask

	task automatic record_word(input word_t w);
		acc_words.push_back(w);
		if (acc_words.size() == WORDS_PER_BEAT)
			model_beat();
	endtask

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic compare_beat(input beat_t exp, input beat_t act);
		if (exp !== act) begin
			errors++;
			$display("ERROR %s tdata expected %h actual %h", cur_test, exp, act);
		end
	endtask

	task automatic compare_keep(input string field, input keep_t exp, input keep_t act);
		if (exp !== act) begin
			errors++;
			$display("ERROR %s %s expected %h actual %h", cur_test, field, exp, act);
		end
	endtask

	task automatic compare_id(input string field, input tid_t exp, input tid_t act);
		if (exp !== act) begin
			errors++;
			$display("ERROR %s %s expected %h actual %h", cur_test, field, exp, act);
		end
	endtask

	task automatic compare_user(input tuser_t exp, input tuser_t act);
		if (exp !== act) begin
			errors++;
			$display("ERROR %s tuser expected %h actual %h", cur_test, exp, act);
		end
	endtask

	task automatic compare_last(input logic exp, input logic act);
		if (exp !== act) begin
			errors++;
			$display("ERROR %s tlast expected %b actual %b", cur_test, exp, act);
		end
	endtask

	// ------------------------------
	// monitor and tready driver
	// ------------------------------
	initial begin
		logic                was_stalled;
		logic [FIELDS_W-1:0] held_fields;
		logic [FIELDS_W-1:0] cur_fields;
		was_stalled = 1'b0;
		forever begin
			@(negedge clk);
			cur_fields = {tx_tdata, tx_tstrb, tx_tkeep, tx_tid, tx_tdest, tx_tuser,
				tx_tlast};
			if (was_stalled && (!tx_tvalid || cur_fields !== held_fields)) begin
				errors++;
				$display("%s: stream fields changed while the beat was stalled", cur_test);
			end
			was_stalled = tx_tvalid && !tx_tready && !rst;
			held_fields = cur_fields;
			if (tx_tvalid && tx_tready && !rst) begin
				got_data.push_back(tx_tdata);
				got_keep.push_back(tx_tkeep);
				got_strb.push_back(tx_tstrb);
				got_tid.push_back(tx_tid);
				got_tdest.push_back(tx_tdest);
				got_tuser.push_back(tx_tuser);
				got_last.push_back(tx_tlast);
			end
		end
	end

	always @(posedge clk) begin
		logic [31:0] r;
		if (rand_ready) begin
			r = lcg_next();
			#2;
			tx_tready = r[17] | r[9];
		end
	end

	// ------------------------------
	// driver and drain
	// ------------------------------
	task automatic push_word(input word_t w);
		logic ok;
		ififo_wdata = w;
		ififo_wen = 1'b1;
		do begin
			@(negedge clk);
			ok = ififo_rdy;
			@(posedge clk);
			#2;
		end while (!ok);
		ififo_wen = 1'b0;
		record_word(w);
	endtask

	task automatic drain_and_check();
		while (got_data.size() < exp_data.size())
			@(posedge clk);
		#2;
		if (got_data.size() != exp_data.size()) begin
			errors++;
			$display("%s: more beats arrived than were sent", cur_test);
		end
		while (exp_data.size() > 0 && got_data.size() > 0) begin
			compare_beat(exp_data.pop_front(), got_data.pop_front());
			compare_keep("tkeep", exp_keep[0], got_keep.pop_front());
			compare_keep("tstrb", exp_keep.pop_front(), got_strb.pop_front());
			compare_id("tid", exp_tid.pop_front(), got_tid.pop_front());
			compare_id("tdest", exp_tdest.pop_front(), got_tdest.pop_front());
			compare_user(exp_tuser.pop_front(), got_tuser.pop_front());
			compare_last(exp_last.pop_front(), got_last.pop_front());
		end
	endtask

	task automatic check_no_extra_beats();
		repeat (50) @(posedge clk);
		#2;
		if (got_data.size() != 0) begin
			errors++;
			$display("%s: beats arrived that were never sent", cur_test);
		end
	endtask

	task automatic push_random_beats(input int n);
		for (int i = 0; i < n * WORDS_PER_BEAT; i++)
			push_word({lcg_next(), lcg_next()});
	endtask

	// ------------------------------
	// tests
	// ------------------------------
	task automatic test_single_beat();
		cur_test = "single_beat";
		for (int k = 0; k < WORDS_PER_BEAT; k++)
			push_word(64'h8000_0000_0000_0000 | (64'h0102_0304_0506_0700 + k * 64'h11));
		drain_and_check();
	endtask

	task automatic test_random_full_rate();
		cur_test = "random_full_rate";
		push_random_beats(200);
		drain_and_check();
	endtask

	task automatic test_random_stalls();
		cur_test = "random_stalls";
		rand_ready = 1'b1;
		push_random_beats(200);
		drain_and_check();
		rand_ready = 1'b0;
		@(posedge clk);
		#2;
		tx_tready = 1'b1;
	endtask

	task automatic test_backpressure();
		int    stall_cnt;
		word_t w;
		cur_test = "backpressure";
		tx_tready = 1'b0;
		stall_cnt = 0;
		w = {lcg_next(), lcg_next()};
		ififo_wen = 1'b1;
		while (stall_cnt < 30) begin
			ififo_wdata = w;
			@(negedge clk);
			if (ififo_rdy) begin
				stall_cnt = 0;
				record_word(w);
				w = {lcg_next(), lcg_next()};
			end else begin
				stall_cnt++;
			end
			@(posedge clk);
			#2;
		end
		ififo_wen = 1'b0;
		tx_tready = 1'b1;
		drain_and_check();
		check_no_extra_beats();
	endtask

	task automatic test_reset_partial();
		cur_test = "reset_partial";
		for (int k = 0; k < 3; k++)
			push_word({lcg_next(), lcg_next()});
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		acc_words.delete(); // reset drops the partial beat.
		push_random_beats(1);
		drain_and_check();
		check_no_extra_beats();
	endtask

	initial begin
		rst = 1'b1;
		tx_tready = 1'b1;
		ififo_wdata = '0;
		ififo_wen = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		test_single_beat();
		test_random_full_rate();
		test_random_stalls();
		test_backpressure();
		test_reset_partial();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

endmodule

//--- tx_stream_out.sv
/*
 * Stream output stage, the result stage.
 *   two-entry skid buffer with a main and a skid register
 *   registered AXI4-Stream transmit port
 */

`timescale 1ns/1ns

module tx_stream_out import dispatch_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	beat_if.sink   beat_i,
	output logic   tx_tvalid,
	output beat_t  tx_tdata,
	output keep_t  tx_tstrb,
	output keep_t  tx_tkeep,
	output tid_t   tx_tid,
	output tdest_t tx_tdest,
	output tuser_t tx_tuser,
	output logic   tx_tlast,
	input  logic   tx_tready
);

	logic                     m_valid;
	logic                     s_valid;
	logic                     in_fire;
	logic                     main_free;
	logic [BEAT_W+SIDE_W-1:0] in_pay;
	logic [BEAT_W+SIDE_W-1:0] m_pay;
	logic [BEAT_W+SIDE_W-1:0] s_pay;

	assign beat_i.ready = !s_valid; // taken from a register only.
	assign in_fire      = beat_i.valid && !s_valid;
	assign main_free    = !m_valid || tx_tready;
	assign in_pay = {beat_i.data, beat_i.keep, beat_i.tid, beat_i.tdest,
		beat_i.tuser, beat_i.last};

	// ------------------------------
	// main and skid registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			m_valid <= 1'b0;
			s_valid <= 1'b0;
		end else if (main_free) begin
			m_valid <= s_valid || in_fire;
			s_valid <= 1'b0;
		end else if (in_fire) begin
			s_valid <= 1'b1; // main is stalled so the beat parks in the skid.
		end
	end

	always_ff @(posedge clk) begin
		if (main_free) begin
			if (s_valid)
				m_pay <= s_pay;
			else if (in_fire)
				m_pay <= in_pay;
		end else if (in_fire) begin
			s_pay <= in_pay;
		end
	end

	assign tx_tvalid = m_valid;
	assign {tx_tdata, tx_tkeep, tx_tid, tx_tdest, tx_tuser, tx_tlast} = m_pay;
	assign tx_tstrb  = tx_tkeep;

endmodule
